// File: Makefile
# Verilator build and run of the load path testbench

SIM = obj_dir/Vlsu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f list.f

run: compile
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" sim.log; then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: common/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------
    // Basic data types
    // ------------------------------

    // Full data word, also used for byte addresses
    typedef logic [31:0] data_word_t;

    // Word index, the byte address without its two offset bits
    typedef logic [29:0] word_addr_t;

    // Size of a load access
    typedef enum logic [1:0] {
        LDB,
        LDH,
        LDW
    } load_width_t;

    // ------------------------------
    // Load micro-operation
    // ------------------------------

    // Selects the access size and whether the result is sign extended
    typedef struct packed {
        load_width_t width;
        logic        signed_load;
    } ldu_uop_t;

    // ------------------------------
    // Memory port
    // ------------------------------

    // Request to the data memory
    // Read and write are never set together, each master keeps its
    // fields at zero while it does not own the port
    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t address;
        data_word_t wdata;
    } mem_req_t;

    // Read response, valid for a single cycle
    typedef struct packed {
        logic       valid;
        data_word_t rdata;
    } mem_rsp_t;

    // ------------------------------
    // Memory map
    // ------------------------------

    // IO window, only reachable from machine mode
    // The lower bound is inclusive and the upper bound is exclusive
    localparam data_word_t IO_START = 32'h0000_0F00;
    localparam data_word_t IO_END   = 32'h0000_1000;

endpackage : lsu_pkg

// File: list.f
common/lsu_pkg.sv
load_store_unit/load_unit.sv
load_store_unit/store_buffer.sv
source/data_memory.sv
source/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

// File: load_store_unit/load_unit.sv
`timescale 1ns/100ps

module load_unit import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // High while the core runs in machine mode
    input  logic       prv_level_i,

    // Load issue
    input  logic       valid_operation_i,
    input  data_word_t load_address_i,
    input  ldu_uop_t   operation_i,

    // Forwarding from the store buffer
    input  logic       fwd_match_i,
    input  data_word_t fwd_data_i,

    // Memory port
    output mem_req_t   mem_req_o,
    input  mem_rsp_t   mem_rsp_i,

    // Result and status
    output data_word_t data_loaded_o,
    output logic       idle_o,
    output logic       illegal_access_o,
    output logic       data_valid_o
);

    typedef enum logic {IDLE, WAIT} ldu_state_t;

    // ------------------------------
    // Privilege check
    // ------------------------------

    // User mode code must not read the IO window
    logic illegal_priv_access;

    assign illegal_priv_access = (load_address_i >= IO_START) & (load_address_i < IO_END)
                                 & !prv_level_i;

    // ------------------------------
    // Operation registers
    // ------------------------------

    ldu_state_t state_q, state_d;
    logic       match_q, match_d;
    data_word_t load_data_q, load_data_d;
    ldu_uop_t   operation_q;
    data_word_t load_address_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            match_q <= 1'b0;
        end else begin
            state_q <= state_d;
            match_q <= match_d;
        end
    end

    // Payload registers are loaded when a new operation is accepted
    always_ff @(posedge clk_i) begin
        load_data_q <= load_data_d;
        if (valid_operation_i && (state_q == IDLE)) begin
            operation_q    <= operation_i;
            load_address_q <= load_address_i;
        end
    end

    // ------------------------------
    // Subword slicing
    // ------------------------------

    // A forwarding hit keeps its word locally and a miss takes the memory data
    data_word_t data_selected;
    data_word_t data_sliced;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    assign data_selected = match_q ? load_data_q : mem_rsp_i.rdata;

    // The byte offset picks the lane and a half-word uses only bit 1
    assign byte_sel = data_selected[8 * load_address_q[1:0] +: 8];
    assign half_sel = data_selected[16 * load_address_q[1] +: 16];

    always_comb begin
        data_sliced = data_selected;
        case (operation_q.width)
            LDB: data_sliced = {{24{operation_q.signed_load & byte_sel[7]}}, byte_sel};
            LDH: data_sliced = {{16{operation_q.signed_load & half_sel[15]}}, half_sel};
            default: data_sliced = data_selected;
        endcase
    end

    // ------------------------------
    // FSM
    // ------------------------------

    always_comb begin
        state_d          = state_q;
        match_d          = match_q;
        load_data_d      = load_data_q;
        mem_req_o        = '0;
        idle_o           = 1'b0;
        data_valid_o     = 1'b0;
        data_loaded_o    = '0;
        illegal_access_o = 1'b0;

        case (state_q)
            IDLE: begin
                idle_o = 1'b1;
                if (valid_operation_i) begin
                    if (illegal_priv_access) begin
                        // Rejected in place with no request and no result
                        illegal_access_o = 1'b1;
                    end else begin
                        state_d = WAIT;
                        if (fwd_match_i) begin
                            // Pending store holds the newest value of this word
                            load_data_d = fwd_data_i;
                            match_d     = 1'b1;
                        end else begin
                            mem_req_o.read    = 1'b1;
                            mem_req_o.address = load_address_i[31:2];
                        end
                    end
                end
            end

            WAIT: begin
                data_loaded_o = data_sliced;
                // Forwarded data finishes at once and memory data after its latency
                if (match_q | mem_rsp_i.valid) begin
                    state_d      = IDLE;
                    match_d      = 1'b0;
                    data_valid_o = 1'b1;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // A result from memory arrives exactly two cycles after its read
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_o && !match_q) |-> $past(mem_req_o.read, 2));

endmodule : load_unit

// File: load_store_unit/store_buffer.sv
`timescale 1ns/100ps

module store_buffer import lsu_pkg::*; #(
    // Number of entries, a power of two of at least two
    parameter int STB_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Store issue, single cycle strobe
    input  logic       store_valid_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,

    // Forwarding lookup from the load unit
    input  data_word_t load_address_i,
    output logic       fwd_match_o,
    output data_word_t fwd_data_o,

    // Load unit owns the memory port in this cycle
    input  logic       load_busy_i,
    output mem_req_t   mem_req_o,

    output logic       stb_full_o
);

    localparam int PTR_W = $clog2(STB_DEPTH);

    typedef struct packed {
        word_addr_t address;
        data_word_t data;
    } stb_entry_t;

    // ------------------------------
    // Storage and pointers
    // ------------------------------

    stb_entry_t       entries [STB_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push, pop;

    assign stb_full_o = (count_q == (PTR_W + 1)'(STB_DEPTH));

    // Full flag is a rule for the issuer, the push is still guarded
    assign push = store_valid_i & !stb_full_o;

    // Drain only in cycles where the load unit leaves the port free
    assign pop = (count_q != '0) & !load_busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            entries[wr_ptr_q] <= '{address: store_address_i[31:2], data: store_data_i};
        end
    end

    // ------------------------------
    // Forwarding search
    // ------------------------------

    // Walk back from the last written slot so the newest match wins
    always_comb begin
        logic [PTR_W-1:0] idx;

        fwd_match_o = 1'b0;
        fwd_data_o  = '0;
        for (int i = 0; i < STB_DEPTH; i++) begin
            idx = wr_ptr_q - PTR_W'(1) - PTR_W'(i);
            if (!fwd_match_o && (i < count_q)
                    && (entries[idx].address == load_address_i[31:2])) begin
                fwd_match_o = 1'b1;
                fwd_data_o  = entries[idx].data;
            end
        end
    end

    // ------------------------------
    // Drain to memory
    // ------------------------------

    always_comb begin
        mem_req_o = '0;
        if (pop) begin
            mem_req_o.write   = 1'b1;
            mem_req_o.address = entries[rd_ptr_q].address;
            mem_req_o.wdata   = entries[rd_ptr_q].data;
        end
    end

    // The issuer has to hold stores back while the buffer is full
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_valid_i |-> !stb_full_o);

endmodule : store_buffer

// File: source/data_memory.sv
`timescale 1ns/100ps

module data_memory import lsu_pkg::*; #(
    // Depth in words
    parameter int MEM_WORDS = 1024
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    data_word_t        mem [MEM_WORDS];
    logic [ADDR_W-1:0] index;

    // Upper word index bits fold onto the array
    assign index = mem_req_i.address[ADDR_W-1:0];

    // Contents start at zero in simulation
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ------------------------------
    // Write port and read pipeline
    // ------------------------------

    logic       valid_s1_q, valid_s2_q;
    data_word_t rdata_s1_q, rdata_s2_q;

    // Writes land at this edge, reads take two stages
    always_ff @(posedge clk_i) begin
        if (mem_req_i.write) mem[index] <= mem_req_i.wdata;
        if (mem_req_i.read) rdata_s1_q <= mem[index];
        rdata_s2_q <= rdata_s1_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_s1_q <= 1'b0;
            valid_s2_q <= 1'b0;
        end else begin
            valid_s1_q <= mem_req_i.read;
            valid_s2_q <= valid_s1_q;
        end
    end

    assign mem_rsp_o = '{valid: valid_s2_q, rdata: rdata_s2_q};

    // Load unit and store buffer never share a cycle on the port
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_req_i.read && mem_req_i.write));

endmodule : data_memory

// File: source/lsu_top.sv
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
    parameter int MEM_WORDS = 1024,
    parameter int STB_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       prv_level_i,

    // Load channel
    input  logic       valid_operation_i,
    input  data_word_t load_address_i,
    input  ldu_uop_t   operation_i,
    output data_word_t data_loaded_o,
    output logic       idle_o,
    output logic       illegal_access_o,
    output logic       data_valid_o,

    // Store channel
    input  logic       store_valid_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    output logic       stb_full_o
);

    logic       fwd_match;
    data_word_t fwd_data;
    mem_req_t   ldu_req, stb_req, mem_req;
    mem_rsp_t   mem_rsp;

    load_unit load_unit_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .prv_level_i       (prv_level_i),
        .valid_operation_i (valid_operation_i),
        .load_address_i    (load_address_i),
        .operation_i       (operation_i),
        .fwd_match_i       (fwd_match),
        .fwd_data_i        (fwd_data),
        .mem_req_o         (ldu_req),
        .mem_rsp_i         (mem_rsp),
        .data_loaded_o     (data_loaded_o),
        .idle_o            (idle_o),
        .illegal_access_o  (illegal_access_o),
        .data_valid_o      (data_valid_o)
    );

    store_buffer #(.STB_DEPTH(STB_DEPTH)) store_buffer_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .store_valid_i   (store_valid_i),
        .store_address_i (store_address_i),
        .store_data_i    (store_data_i),
        .load_address_i  (load_address_i),
        .fwd_match_o     (fwd_match),
        .fwd_data_o      (fwd_data),
        .load_busy_i     (ldu_req.read),
        .mem_req_o       (stb_req),
        .stb_full_o      (stb_full_o)
    );

    // Idle masters drive zeros, so a plain OR merges the two requests
    assign mem_req.read    = ldu_req.read | stb_req.read;
    assign mem_req.write   = ldu_req.write | stb_req.write;
    assign mem_req.address = ldu_req.address | stb_req.address;
    assign mem_req.wdata   = ldu_req.wdata | stb_req.wdata;

    data_memory #(.MEM_WORDS(MEM_WORDS)) data_memory_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule : lsu_top

// File: verification/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker import lsu_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       end_of_test_i,

    // Inputs driven into the DUT
    input  logic       prv_level_i,
    input  logic       valid_operation_i,
    input  data_word_t load_address_i,
    input  ldu_uop_t   operation_i,
    input  logic       store_valid_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,

    // DUT responses
    input  data_word_t data_loaded_i,
    input  logic       idle_i,
    input  logic       illegal_access_i,
    input  logic       data_valid_i,
    input  logic       stb_full_i,

    output int         error_count_o,
    output int         load_count_o,
    output int         store_count_o
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    // Architectural view of memory, every accepted store lands here at once
    data_word_t ref_mem [MEM_WORDS];

    data_word_t expected_data;
    data_word_t pending_addr;
    ldu_uop_t   pending_op;
    logic       pending;
    logic       reset_checked;
    logic       rejected_last;
    logic       full_seen   = 1'b0;
    logic       final_done  = 1'b0;
    int         wait_cycles;
    int         error_count = 0;
    int         load_count  = 0;
    int         store_count = 0;

    assign error_count_o = error_count;
    assign load_count_o  = load_count;
    assign store_count_o = store_count;

    // ------------------------------
    // Expected values
    // ------------------------------

    // Shift the addressed lane down, then extend it to a full word
    function automatic data_word_t expected_load(data_word_t word, logic [1:0] offset,
                                                 load_width_t width, logic sgn);
        data_word_t shifted;

        shifted = word >> (8 * offset);
        case (width)
            LDB: return (sgn && shifted[7]) ? {24'hFF_FFFF, shifted[7:0]}
                                            : {24'h00_0000, shifted[7:0]};
            LDH: return (sgn && shifted[15]) ? {16'hFFFF, shifted[15:0]}
                                             : {16'h0000, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_fault(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    always @(posedge clk_i) begin
        logic illegal_exp;

        if (!rst_n_i) begin
            pending       = 1'b0;
            reset_checked = 1'b0;
            rejected_last = 1'b0;
            wait_cycles   = 0;
            // Memory contents start at zero, as in the DUT
            for (int i = 0; i < MEM_WORDS; i++) begin
                ref_mem[i] = '0;
            end
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!idle_i || data_valid_i || stb_full_i) begin
                    report_mismatch($sformatf("after reset idle=%b data_valid=%b stb_full=%b",
                                              idle_i, data_valid_i, stb_full_i));
                end
            end
            if (stb_full_i) full_seen = 1'b1;

            // A rejected load must leave the unit free on the next cycle
            if (rejected_last && !idle_i) begin
                report_mismatch("load unit left IDLE after a rejected load");
            end
            rejected_last = 1'b0;

            // ------------------------------
            // Result of the outstanding load
            // ------------------------------
            if (data_valid_i) begin
                if (!pending) begin
                    report_fault("data_valid_o pulsed while no load was outstanding");
                end else begin
                    if (data_loaded_i !== expected_data) begin
                        report_mismatch($sformatf("load 0x%08h %s signed=%0b got 0x%08h exp 0x%08h",
                            pending_addr, pending_op.width.name(), pending_op.signed_load,
                            data_loaded_i, expected_data));
                    end
                    load_count++;
                    pending = 1'b0;
                end
            end else if (pending) begin
                wait_cycles++;
                if (wait_cycles == 2) begin
                    report_mismatch($sformatf("no data_valid_o within two cycles of load 0x%08h",
                                              pending_addr));
                end
            end

            // A load sees memory as it was before a store strobed in the same cycle
            if (valid_operation_i && idle_i) begin
                illegal_exp = (load_address_i >= IO_START) && (load_address_i < IO_END)
                              && !prv_level_i;
                if (illegal_access_i !== illegal_exp) begin
                    report_mismatch($sformatf("illegal_access_o=%b for load 0x%08h prv=%b",
                                              illegal_access_i, load_address_i, prv_level_i));
                end
                if (illegal_exp) begin
                    rejected_last = 1'b1;
                end else begin
                    pending       = 1'b1;
                    wait_cycles   = 0;
                    pending_addr  = load_address_i;
                    pending_op    = operation_i;
                    expected_data = expected_load(ref_mem[load_address_i[ADDR_W+1:2]],
                                                  load_address_i[1:0], operation_i.width,
                                                  operation_i.signed_load);
                end
            end else if (illegal_access_i) begin
                report_mismatch("illegal_access_o raised without an accepted load");
            end

            if (store_valid_i && !stb_full_i) begin
                ref_mem[store_address_i[ADDR_W+1:2]] = store_data_i;
                store_count++;
            end

            if (end_of_test_i && !final_done) begin
                final_done = 1'b1;
                if (pending) report_fault("a load was still outstanding at the end of the test");
                if (!full_seen) report_fault("stb_full_o was never raised during the test");
            end
        end
    end

endmodule : lsu_checker

// File: verification/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb import lsu_pkg::*; ();

    localparam int MEM_WORDS  = 1024;
    localparam int STB_DEPTH  = 4;
    localparam int NUM_STIM   = 38;
    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT_CYCLES = 20 * (NUM_STIM + NUM_RANDOM) + 100;
    localparam logic [31:0] SEED = 32'he526_2e10;

    // ------------------------------
    // Stimulus format
    // ------------------------------

    // OP_STLD puts a store and a load into the same cycle
    typedef enum logic [1:0] {OP_ST, OP_LD, OP_STLD} op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        data_word_t  st_addr;
        data_word_t  data;
        data_word_t  ld_addr;
        load_width_t width;
        logic        sgn;
        logic        prv;
    } tb_op_t;

    // DUT signals, named after the ports so the instance connects by name
    logic       clk_i;
    logic       rst_n_i;
    logic       prv_level_i;
    logic       valid_operation_i;
    data_word_t load_address_i;
    ldu_uop_t   operation_i;
    data_word_t data_loaded_o;
    logic       idle_o;
    logic       illegal_access_o;
    logic       data_valid_o;
    logic       store_valid_i;
    data_word_t store_address_i;
    data_word_t store_data_i;
    logic       stb_full_o;

    logic end_of_test;
    int   error_count;
    int   load_count;
    int   store_count;
    int   cycle_count = 0;

    // Columns: kind, store address, store data, load address, width, signed, privilege
    tb_op_t stim_table [NUM_STIM] = '{
        // Word stores, the second write to 0x100 replaces the first
        '{OP_ST,   32'h100, 32'h1122_3344, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h104, 32'hA5B6_C7D8, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h100, 32'hCAFE_BABE, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h104, LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h100, LDW, 1'b0, 1'b1},
        // Subword loads over a word with a mix of sign bits
        '{OP_ST,   32'h108, 32'h80F1_7F82, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h108, LDB, 1'b1, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h109, LDB, 1'b1, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10A, LDB, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10B, LDB, 1'b1, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10B, LDB, 1'b0, 1'b0},
        '{OP_LD,   32'h0,   32'h0,         32'h108, LDH, 1'b1, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10A, LDH, 1'b1, 1'b0},
        '{OP_LD,   32'h0,   32'h0,         32'h10A, LDH, 1'b0, 1'b1},
        // Load right behind a store to the same word takes the forwarded data
        '{OP_ST,   32'h10C, 32'h1234_8765, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10C, LDH, 1'b1, 1'b1},
        '{OP_ST,   32'h10C, 32'hDEAD_BEEF, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h10F, LDB, 1'b0, 1'b0},
        // IO window, rejected in user mode and served in machine mode
        '{OP_ST,   32'hF40, 32'h0BAD_F00D, 32'h0,   LDW, 1'b0, 1'b0},
        '{OP_LD,   32'h0,   32'h0,         32'hF40, LDW, 1'b0, 1'b0},
        '{OP_LD,   32'h0,   32'h0,         32'hF40, LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'hFFE, LDH, 1'b1, 1'b0},
        '{OP_LD,   32'h0,   32'h0,         32'hEFC, LDW, 1'b0, 1'b0},
        // Every paired load misses and blocks one drain, so the buffer fills up
        '{OP_STLD, 32'h180, 32'h0101_0101, 32'h300, LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h184, 32'h0202_0202, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h180, 32'h0303_0303, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_STLD, 32'h188, 32'h0404_0404, 32'h304, LDB, 1'b1, 1'b1},
        '{OP_ST,   32'h18C, 32'h0505_0505, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h180, 32'h0606_0606, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_STLD, 32'h184, 32'h0707_0707, 32'h308, LDH, 1'b0, 1'b1},
        '{OP_ST,   32'h188, 32'h0808_0808, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h180, 32'h0909_0909, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_STLD, 32'h18C, 32'h0A0A_0A0A, 32'h30C, LDW, 1'b0, 1'b1},
        '{OP_ST,   32'h180, 32'h8B8B_8B8B, 32'h0,   LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h180, LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h184, LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h188, LDW, 1'b0, 1'b1},
        '{OP_LD,   32'h0,   32'h0,         32'h18C, LDW, 1'b0, 1'b1}
    };

    lsu_top #(.MEM_WORDS(MEM_WORDS), .STB_DEPTH(STB_DEPTH)) lsu_top_i (.*);

    lsu_checker #(.MEM_WORDS(MEM_WORDS)) lsu_checker_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .end_of_test_i     (end_of_test),
        .prv_level_i       (prv_level_i),
        .valid_operation_i (valid_operation_i),
        .load_address_i    (load_address_i),
        .operation_i       (operation_i),
        .store_valid_i     (store_valid_i),
        .store_address_i   (store_address_i),
        .store_data_i      (store_data_i),
        .data_loaded_i     (data_loaded_o),
        .idle_i            (idle_o),
        .illegal_access_i  (illegal_access_o),
        .data_valid_i      (data_valid_o),
        .stb_full_i        (stb_full_o),
        .error_count_o     (error_count),
        .load_count_o      (load_count),
        .store_count_o     (store_count)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress",
                     TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------
    // Driver
    // ------------------------------

    // Called 1 ns after a rising edge, returns 1 ns after the edge that took the op
    task automatic issue_op(input tb_op_t op);
        logic do_st;
        logic do_ld;

        do_st = (op.kind != OP_LD);
        do_ld = (op.kind != OP_ST);
        while ((do_ld && !idle_o) || (do_st && stb_full_o)) begin
            @(posedge clk_i);
            #1;
        end
        store_valid_i     = do_st;
        store_address_i   = op.st_addr;
        store_data_i      = op.data;
        valid_operation_i = do_ld;
        load_address_i    = op.ld_addr;
        operation_i       = '{width: op.width, signed_load: op.sgn};
        prv_level_i       = op.prv;
        @(posedge clk_i);
        #1;
        store_valid_i     = 1'b0;
        valid_operation_i = 1'b0;
    endtask

    // Small address pool so that loads often hit pending stores
    function automatic tb_op_t random_op();
        tb_op_t     op;
        data_word_t base;

        op.kind = op_kind_t'(2'($urandom_range(0, 2)));
        // About one access in eight goes to the IO window
        base = ($urandom_range(0, 7) == 0) ? 32'h0000_0F40 : 32'h0000_0100;
        op.st_addr = base + (32'($urandom_range(0, 7)) << 2);
        op.ld_addr = base + (32'($urandom_range(0, 7)) << 2);
        op.width   = load_width_t'(2'($urandom_range(0, 2)));
        case (op.width)
            LDB: op.ld_addr = op.ld_addr + 32'($urandom_range(0, 3));
            LDH: op.ld_addr = op.ld_addr + 32'(2 * $urandom_range(0, 1));
            default: op.ld_addr = op.ld_addr;
        endcase
        op.data = $urandom();
        op.sgn  = 1'($urandom_range(0, 1));
        op.prv  = 1'($urandom_range(0, 1));
        return op;
    endfunction

    initial begin
        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        prv_level_i       = 1'b1;
        valid_operation_i = 1'b0;
        load_address_i    = '0;
        operation_i       = '0;
        store_valid_i     = 1'b0;
        store_address_i   = '0;
        store_data_i      = '0;
        end_of_test       = 1'b0;
        void'($urandom(SEED));

        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        foreach (stim_table[i]) begin
            issue_op(stim_table[i]);
        end
        repeat (NUM_RANDOM) begin
            issue_op(random_op());
        end

        // Let the last load return and the buffer empty out
        while (!idle_o) begin
            @(posedge clk_i);
            #1;
        end
        repeat (STB_DEPTH + 4) @(posedge clk_i);
        #1;
        end_of_test = 1'b1;
        @(posedge clk_i);
        #1;

        $display("Summary: %0d loads and %0d stores checked, %0d errors",
                 load_count, store_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : lsu_tb
